/* Bender.yml */
package:
  name: cpu_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isa_pkg.sv
      - hdl/bus_pkg.sv
      - hdl/fetchUnit.sv
      - hdl/executeUnit.sv
      - hdl/loadStoreUnit.sv
      - hdl/cpuCore.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/memModel.sv
      - bench/cpuCore_asserts.sv
      - bench/tb_cpuCore.sv

/* bench/cpuCore_asserts.sv */
`timescale 1ns/1ps

module cpuCore_asserts import bus_pkg::*; (
    input logic     i_Clk,
    input logic     i_rstN,
    input busAddr_t i_IAddr,
    input logic     i_IRead,
    input logic     i_IWait,
    input logic     i_DReq,
    input busAddr_t i_DAddr,
    input byteEn_t  i_DByteEn,
    input logic     i_DRead,
    input logic     i_DWrite,
    input logic     i_DWait
);

    int failCount = 0;

    noReadAndWrite: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        !(i_DRead && i_DWrite))
        else begin
            failCount++;
            $error("data bus read and write asserted together");
        end

    // Registers are still unknown at the first reset edge
    quietInReset: assert property (@(posedge i_Clk)
        (!i_rstN && $past(!i_rstN)) |-> !(i_IRead || i_DRead || i_DWrite || i_DReq))
        else begin
            failCount++;
            $error("bus strobe active during reset");
        end

    iBusHold: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        (i_IRead && i_IWait) |=> (i_IRead && $stable(i_IAddr)))
        else begin
            failCount++;
            $error("instruction request changed under wait request");
        end

    dBusHold: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        ((i_DRead || i_DWrite) && i_DWait) |=>
            ($stable(i_DRead) && $stable(i_DWrite) && $stable(i_DAddr) && $stable(i_DByteEn)))
        else begin
            failCount++;
            $error("data request changed under wait request");
        end

endmodule

bind cpuCore cpuCore_asserts asserts_i (
    .i_Clk     (i_Clk),
    .i_rstN    (i_rstN),
    .i_IAddr   (o_IBus_Address),
    .i_IRead   (o_IBus_Read),
    .i_IWait   (i_IBus_WaitReq),
    .i_DReq    (o_DBus_Req),
    .i_DAddr   (o_DBus_Address),
    .i_DByteEn (o_DBus_ByteEn),
    .i_DRead   (o_DBus_Read),
    .i_DWrite  (o_DBus_Write),
    .i_DWait   (i_DBus_WaitRequest)
);

/* bench/cpu_vectors.txt */
// Words 00..2F: program, one instruction per word at byte address 4*index
// Word 80: record count, then records of word address, byte enables, masked write data
@00
10000093 // addi x1, x0, 0x100
FFB00113 // addi x2, x0, -5
00300193 // addi x3, x0, 3
00310233 // add  x4, x2, x3
0040A023 // sw   x4, 0(x1)
402182B3 // sub  x5, x3, x2
40315333 // sra  x6, x2, x3
0050A223 // sw   x5, 4(x1)
0060A423 // sw   x6, 8(x1)
003123B3 // slt  x7, x2, x3
0F03C413 // xori x8, x7, 0xf0
00441493 // slli x9, x8, 4
01C15513 // srli x10, x2, 28
00A4E5B3 // or   x11, x9, x10
00B0A623 // sw   x11, 12(x1)
12345637 // lui  x12, 0x12345
67860613 // addi x12, x12, 0x678
00001697 // auipc x13, 1
00D0A823 // sw   x13, 16(x1)
00208AA3 // sb   x2, 21(x1)
00C09B23 // sh   x12, 22(x1)
01508703 // lb   x14, 21(x1)
00E0AC23 // sw   x14, 24(x1)
0150C783 // lbu  x15, 21(x1)
0140D883 // lhu  x17, 20(x1)
01409903 // lh   x18, 20(x1)
0140A983 // lw   x19, 20(x1)
01178A33 // add  x20, x15, x17
0140AE23 // sw   x20, 28(x1)
0320A023 // sw   x18, 32(x1)
0330A223 // sw   x19, 36(x1)
00318463 // beq  x3, x3, +8
0200A423 // sw   x0, 40(x1) skipped
00319463 // bne  x3, x3, +8
0230A623 // sw   x3, 44(x1)
00314463 // blt  x2, x3, +8
0200A423 // sw   x0, 40(x1) skipped
00315463 // bge  x2, x3, +8
00C00AEF // jal  x21, +12
0200A423 // sw   x0, 40(x1) skipped
0200A423 // sw   x0, 40(x1) skipped
0350A823 // sw   x21, 48(x1)
0B800B13 // addi x22, x0, 0xb8
000B0BE7 // jalr x23, 0(x22)
0200A423 // sw   x0, 40(x1) skipped
0200A423 // sw   x0, 40(x1) skipped
0370AA23 // sw   x23, 52(x1)
0000006F // jal  x0, 0
@80
0000000E
00000040 0000000F FFFFFFFE
00000041 0000000F 00000008
00000042 0000000F FFFFFFFF
00000043 0000000F 00000F1F
00000044 0000000F 00001044
00000045 00000002 0000FB00
00000045 0000000C 56780000
00000046 0000000F FFFFFFFB
00000047 0000000F 0000FBFB
00000048 0000000F FFFFFB00
00000049 0000000F 5678FB00
0000004B 0000000F 00000003
0000004C 0000000F 0000009C
0000004D 0000000F 000000B0

/* bench/memModel.sv */
`timescale 1ns/1ps

module memModel import bus_pkg::*; (
    input  logic     i_Clk,
    input  logic     i_rstN,

    // Instruction side
    input  busAddr_t i_IAddr,
    input  logic     i_IRead,
    output word_t    o_IRdata,
    output logic     o_IWait,

    // Data side
    input  logic     i_DReq,
    output logic     o_DGnt,
    input  busAddr_t i_DAddr,
    input  byteEn_t  i_DByteEn,
    input  logic     i_DRead,
    input  logic     i_DWrite,
    input  word_t    i_DWdata,
    output word_t    o_DRdata,
    output logic     o_DWait
);

    word_t imem [256];
    word_t dmem [256];
    int    iLeft;
    int    gntLeft;
    int    dLeft;

    initial begin
        // Unused instruction slots hold a custom opcode, which executes as a no-op
        for (int i = 0; i < 256; i++) begin
            imem[i] = {i[24:0], 7'h0B};
            dmem[i] = '0;
        end
        $readmemh("bench/cpu_vectors.txt", imem);
        iLeft   = 0;
        gntLeft = 0;
        dLeft   = 0;
        o_IWait = 1'b1;
        o_DGnt  = 1'b0;
        o_DWait = 1'b1;
    end

    assign o_IRdata = (i_IAddr < 256) ? imem[i_IAddr[7:0]] : {i_IAddr[24:0], 7'h0B};
    assign o_DRdata = dmem[i_DAddr[7:0]];

    always @(negedge i_Clk) begin
        if (!i_rstN) begin
            o_IWait <= 1'b1;
            o_DGnt  <= 1'b0;
            o_DWait <= 1'b1;
        end else begin
            // Each fetch waits 0 to 3 cycles before its window opens
            if (iLeft == 0) begin
                o_IWait <= 1'b0;
                if (i_IRead) begin
                    iLeft <= $urandom % 4;
                end
            end else begin
                o_IWait <= 1'b1;
                if (i_IRead) begin
                    iLeft <= iLeft - 1;
                end
            end

            if (!i_DReq) begin
                o_DGnt  <= 1'b0;
                gntLeft <= $urandom % 4;
            end else if (gntLeft == 0) begin
                o_DGnt <= 1'b1;
            end else begin
                o_DGnt  <= 1'b0;
                gntLeft <= gntLeft - 1;
            end

            if (!(i_DRead || i_DWrite)) begin
                o_DWait <= 1'b1;
                dLeft   <= $urandom % 4;
            end else if (dLeft == 0) begin
                o_DWait <= 1'b0;
                if (i_DWrite) begin
                    for (int b = 0; b < 4; b++) begin
                        if (i_DByteEn[b]) begin
                            dmem[i_DAddr[7:0]][b*8 +: 8] = i_DWdata[b*8 +: 8];
                        end
                    end
                end
            end else begin
                o_DWait <= 1'b1;
                dLeft   <= dLeft - 1;
            end
        end
    end

endmodule

/* bench/tb_cpuCore.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpuCore
    import bus_pkg::*;
();

    logic     i_Clk;
    logic     i_rstN;
    busAddr_t o_IBus_Address;
    logic     o_IBus_Read;
    word_t    i_IBus_ReadData;
    logic     i_IBus_WaitReq;
    logic     o_DBus_Req;
    logic     i_DBus_Gnt;
    busAddr_t o_DBus_Address;
    byteEn_t  o_DBus_ByteEn;
    logic     o_DBus_Read;
    logic     o_DBus_Write;
    word_t    i_DBus_ReadData;
    word_t    o_DBus_WriteData;
    logic     i_DBus_WaitRequest;

    logic [31:0] vecMem [0:255];
    int          checkErrors;
    int          otherErrors;
    int          expCount;
    int          writeCount;
    logic [31:0] finalAddr;
    logic        finalSeen;

    cpuCore dut_i (.*);

    memModel mem_i (
        .i_Clk     (i_Clk),
        .i_rstN    (i_rstN),
        .i_IAddr   (o_IBus_Address),
        .i_IRead   (o_IBus_Read),
        .o_IRdata  (i_IBus_ReadData),
        .o_IWait   (i_IBus_WaitReq),
        .i_DReq    (o_DBus_Req),
        .o_DGnt    (i_DBus_Gnt),
        .i_DAddr   (o_DBus_Address),
        .i_DByteEn (o_DBus_ByteEn),
        .i_DRead   (o_DBus_Read),
        .i_DWrite  (o_DBus_Write),
        .i_DWdata  (o_DBus_WriteData),
        .o_DRdata  (i_DBus_ReadData),
        .o_DWait   (i_DBus_WaitRequest)
    );

    always #10 i_Clk = ~i_Clk;

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            checkErrors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic word_t laneMask(input byteEn_t be);
        word_t mask;
        for (int b = 0; b < 4; b++) begin
            mask[b*8 +: 8] = {8{be[b]}};
        end
        return mask;
    endfunction

    // Three-word records follow the count word
    task automatic recordWrite();
        int base;
        base = 'h81 + 3 * writeCount;
        if (writeCount >= expCount) begin
            otherErrors++;
            $display("Unexpected extra write to word address %h", o_DBus_Address);
        end else begin
            checkValue("o_DBus_Address", 32'(o_DBus_Address), vecMem[base]);
            checkValue("o_DBus_ByteEn", 32'(o_DBus_ByteEn), vecMem[base + 1]);
            checkValue("o_DBus_WriteData", o_DBus_WriteData & laneMask(o_DBus_ByteEn),
                       vecMem[base + 2]);
        end
        if (32'(o_DBus_Address) == finalAddr) begin
            finalSeen = 1'b1;
        end
        writeCount++;
    endtask

    task automatic finishRun();
        int assertErrors;
        assertErrors = dut_i.asserts_i.failCount;
        $display("Errors: %0d check, %0d assertion, %0d other",
                 checkErrors, assertErrors, otherErrors);
        if (checkErrors == 0 && assertErrors == 0 && otherErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    always @(posedge i_Clk) begin
        if (i_rstN && o_DBus_Write && !i_DBus_WaitRequest) begin
            recordWrite();
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'hfe66a7f2));
        i_Clk       = 1'b0;
        i_rstN      = 1'b0;
        checkErrors = 0;
        otherErrors = 0;
        writeCount  = 0;
        finalSeen   = 1'b0;
        $readmemh("bench/cpu_vectors.txt", vecMem);
        expCount  = vecMem['h80];
        finalAddr = vecMem['h81 + 3 * (expCount - 1)];

        for (int i = 0; i < 16; i++) begin
            @(negedge i_Clk);
            checkValue("o_IBus_Read", 32'(o_IBus_Read), 32'd0);
            checkValue("o_DBus_Read", 32'(o_DBus_Read), 32'd0);
            checkValue("o_DBus_Write", 32'(o_DBus_Write), 32'd0);
            checkValue("o_DBus_Req", 32'(o_DBus_Req), 32'd0);
        end
        i_rstN = 1'b1;

        cycles = 0;
        while (!o_IBus_Read && cycles < 20) begin
            @(negedge i_Clk);
            cycles++;
        end
        if (!o_IBus_Read) begin
            otherErrors++;
            $display("No instruction read was issued after reset");
        end else begin
            checkValue("o_IBus_Address", 32'(o_IBus_Address), `CPU_RESET_PC >> 2);

            cycles = 0;
            while (!finalSeen && cycles < 4000) begin
                @(negedge i_Clk);
                cycles++;
            end
            if (!finalSeen) begin
                otherErrors++;
                $display("Timed out waiting for the store to the final address");
            end else begin
                // Let any stray store show up before counting
                repeat (20) @(negedge i_Clk);
                if (writeCount != expCount) begin
                    otherErrors++;
                    $display("Saw %0d data writes but expected %0d", writeCount, expCount);
                end
            end
        end
        finishRun();
    end

endmodule

/* hdl/bus_pkg.sv */
`include "cpu_defines.svh"

package bus_pkg;
    import isa_pkg::*;

    typedef logic [31:0]            word_t;
    typedef logic [`BUS_ADDR_W-1:0] busAddr_t;
    typedef logic [3:0]             byteEn_t;

    typedef struct packed {
        busAddr_t addr;
        logic     read;
    } iBusReq_t;

    typedef struct packed {
        busAddr_t addr;
        byteEn_t  byteEn;
        logic     read;
        logic     write;
        word_t    wdata;
    } dBusReq_t;

    // Execute to load/store stage, size is the raw funct3
    typedef struct packed {
        logic     valid;
        logic     isLoad;
        logic     isStore;
        funct3_t  size;
        word_t    addr;
        word_t    storeData;
        regAddr_t rd;
        logic     regWrite;
        word_t    result;
    } memOp_t;

endpackage

/* hdl/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore import isa_pkg::*, bus_pkg::*; (
    input  logic     i_Clk,
    input  logic     i_rstN,

    // Instruction bus master
    output busAddr_t o_IBus_Address,
    output logic     o_IBus_Read,
    input  word_t    i_IBus_ReadData,
    input  logic     i_IBus_WaitReq,

    // Data bus master
    output logic     o_DBus_Req,
    input  logic     i_DBus_Gnt,
    output busAddr_t o_DBus_Address,
    output byteEn_t  o_DBus_ByteEn,
    output logic     o_DBus_Read,
    output logic     o_DBus_Write,
    input  word_t    i_DBus_ReadData,
    output word_t    o_DBus_WriteData,
    input  logic     i_DBus_WaitRequest
);

    fetched_t fetched;
    logic     stall;
    logic     redirect;
    word_t    target;
    memOp_t   memOp;
    logic     lsuBusy;
    logic     wbEn;
    regAddr_t wbReg;
    word_t    wbData;
    iBusReq_t iBusReq;
    dBusReq_t dBusReq;

    assign o_IBus_Address   = iBusReq.addr;
    assign o_IBus_Read      = iBusReq.read;
    assign o_DBus_Address   = dBusReq.addr;
    assign o_DBus_ByteEn    = dBusReq.byteEn;
    assign o_DBus_Read      = dBusReq.read;
    assign o_DBus_Write     = dBusReq.write;
    assign o_DBus_WriteData = dBusReq.wdata;

    fetchUnit fetch_i (
        .i_Clk         (i_Clk),
        .i_rstN        (i_rstN),
        .i_Stall       (stall),
        .i_Redirect    (redirect),
        .i_Target      (target),
        .o_IBusReq     (iBusReq),
        .i_IBusWaitReq (i_IBus_WaitReq),
        .i_IBusRdata   (i_IBus_ReadData),
        .o_Fetched     (fetched)
    );

    executeUnit execute_i (
        .i_Clk      (i_Clk),
        .i_rstN     (i_rstN),
        .i_Fetched  (fetched),
        .i_LsuBusy  (lsuBusy),
        .i_WbEn     (wbEn),
        .i_WbReg    (wbReg),
        .i_WbData   (wbData),
        .o_Stall    (stall),
        .o_Redirect (redirect),
        .o_Target   (target),
        .o_MemOp    (memOp)
    );

    loadStoreUnit lsu_i (
        .i_Clk         (i_Clk),
        .i_rstN        (i_rstN),
        .i_MemOp       (memOp),
        .o_Busy        (lsuBusy),
        .o_DBusReq     (o_DBus_Req),
        .i_DBusGnt     (i_DBus_Gnt),
        .o_DBus        (dBusReq),
        .i_DBusRdata   (i_DBus_ReadData),
        .i_DBusWaitReq (i_DBus_WaitRequest),
        .o_WbEn        (wbEn),
        .o_WbReg       (wbReg),
        .o_WbData      (wbData)
    );

endmodule

/* hdl/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Byte address of the first instruction fetch
`define CPU_RESET_PC 32'h0000_0000

// Word address width on both buses
`define BUS_ADDR_W 30

// Architectural registers, x0 included
`define CPU_REG_COUNT 32

`endif

/* hdl/executeUnit.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module executeUnit import isa_pkg::*, bus_pkg::*; (
    input  logic     i_Clk,
    input  logic     i_rstN,
    input  fetched_t i_Fetched,
    input  logic     i_LsuBusy,
    input  logic     i_WbEn,
    input  regAddr_t i_WbReg,
    input  word_t    i_WbData,
    output logic     o_Stall,
    output logic     o_Redirect,
    output word_t    o_Target,
    output memOp_t   o_MemOp
);

    word_t    regFile [`CPU_REG_COUNT];
    instr_t   inst;
    opcode_e  opcode;
    funct3_t  funct3;
    regAddr_t rs1;
    regAddr_t rs2;
    regAddr_t rd;
    ctrl_t    ctrl;
    aluOp_e   aluFn;
    word_t    imm;
    word_t    rs1Val;
    word_t    rs2Val;
    word_t    aluA;
    word_t    aluB;
    word_t    aluRes;
    logic     taken;
    word_t    linkPc;
    memOp_t   memOp;

    assign inst   = i_Fetched.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    // Shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b000:  aluFn = (opcode == OP_REG && inst[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  aluFn = ALU_SLL;
            3'b010:  aluFn = ALU_SLT;
            3'b100:  aluFn = ALU_XOR;
            3'b101:  aluFn = inst[30] ? ALU_SRA : ALU_SRL;
            3'b110:  aluFn = ALU_OR;
            3'b111:  aluFn = ALU_AND;
            default: aluFn = ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = ALU_ADD;
        ctrl.upper = UP_NONE;
        if (i_Fetched.valid) begin
            case (opcode)
                OP_LUI: begin
                    ctrl.aluOp    = ALU_PASSB;
                    ctrl.bSelImm  = 1'b1;
                    ctrl.upper    = UP_LUI;
                    ctrl.regWrite = 1'b1;
                end
                OP_AUIPC: begin
                    ctrl.bSelImm  = 1'b1;
                    ctrl.upper    = UP_AUIPC;
                    ctrl.regWrite = 1'b1;
                end
                OP_JAL: begin
                    ctrl.isJal    = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
                OP_JALR: begin
                    ctrl.isJalr   = 1'b1;
                    ctrl.bSelImm  = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
                OP_BRANCH: begin
                    ctrl.isBranch = funct3 inside {3'b000, 3'b001, 3'b100, 3'b101};
                end
                OP_LOAD: begin
                    ctrl.memRead  = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
                    ctrl.bSelImm  = 1'b1;
                    ctrl.regWrite = ctrl.memRead;
                end
                OP_STORE: begin
                    ctrl.memWrite = funct3 inside {3'b000, 3'b001, 3'b010};
                    ctrl.bSelImm  = 1'b1;
                end
                OP_IMM: begin
                    ctrl.aluOp    = aluFn;
                    ctrl.bSelImm  = 1'b1;
                    ctrl.regWrite = funct3 != 3'b011;
                end
                OP_REG: begin
                    ctrl.aluOp    = aluFn;
                    ctrl.regWrite = funct3 != 3'b011;
                end
                default: begin
                    ctrl.regWrite = 1'b0;
                end
            endcase
        end
    end

    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC: imm = {inst[31:12], 12'd0};
            OP_JAL:    imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            OP_BRANCH: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            OP_STORE:  imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            default:   imm = {{21{inst[31]}}, inst[30:20]};
        endcase
    end

    always_ff @(posedge i_Clk) begin
        if (i_WbEn && i_WbReg != 5'd0) begin
            regFile[i_WbReg] <= i_WbData;
        end
    end

    // Write-back in flight overrides the stale register value
    function automatic word_t readReg(input regAddr_t addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (i_WbEn && i_WbReg == addr) begin
            return i_WbData;
        end
        return regFile[addr];
    endfunction

    always_comb begin
        rs1Val = readReg(rs1);
        rs2Val = readReg(rs2);
    end

    assign aluA = (ctrl.upper == UP_AUIPC) ? i_Fetched.pc : rs1Val;
    assign aluB = ctrl.bSelImm ? imm : rs2Val;

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD:   aluRes = aluA + aluB;
            ALU_SUB:   aluRes = aluA - aluB;
            ALU_SLL:   aluRes = aluA << aluB[4:0];
            ALU_SLT:   aluRes = {31'd0, $signed(aluA) < $signed(aluB)};
            ALU_XOR:   aluRes = aluA ^ aluB;
            ALU_SRL:   aluRes = aluA >> aluB[4:0];
            ALU_SRA:   aluRes = $unsigned($signed(aluA) >>> aluB[4:0]);
            ALU_OR:    aluRes = aluA | aluB;
            ALU_AND:   aluRes = aluA & aluB;
            default:   aluRes = aluB;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  taken = rs1Val == rs2Val;
            3'b001:  taken = rs1Val != rs2Val;
            3'b100:  taken = $signed(rs1Val) < $signed(rs2Val);
            default: taken = $signed(rs1Val) >= $signed(rs2Val);
        endcase
    end

    assign linkPc = i_Fetched.pc + 32'd4;

    // Only redirect once the instruction really leaves execute
    assign o_Stall    = i_LsuBusy;
    assign o_Redirect = !i_LsuBusy && (ctrl.isJal || ctrl.isJalr || (ctrl.isBranch && taken));
    assign o_Target   = ctrl.isJalr ? {aluRes[31:1], 1'b0} : i_Fetched.pc + imm;

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            memOp.valid    <= 1'b0;
            memOp.isLoad   <= 1'b0;
            memOp.isStore  <= 1'b0;
            memOp.regWrite <= 1'b0;
        end else if (!i_LsuBusy) begin
            memOp.valid     <= i_Fetched.valid;
            memOp.isLoad    <= ctrl.memRead;
            memOp.isStore   <= ctrl.memWrite;
            memOp.size      <= funct3;
            memOp.addr      <= aluRes;
            memOp.storeData <= rs2Val;
            memOp.rd        <= rd;
            memOp.regWrite  <= ctrl.regWrite;
            memOp.result    <= (ctrl.isJal || ctrl.isJalr) ? linkPc : aluRes;
        end
    end

    assign o_MemOp = memOp;

endmodule

/* hdl/fetchUnit.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetchUnit import isa_pkg::*, bus_pkg::*; (
    input  logic     i_Clk,
    input  logic     i_rstN,
    input  logic     i_Stall,
    input  logic     i_Redirect,
    input  word_t    i_Target,
    output iBusReq_t o_IBusReq,
    input  logic     i_IBusWaitReq,
    input  word_t    i_IBusRdata,
    output fetched_t o_Fetched
);

    pc_t      pc;
    pc_t      redirPc;
    logic     redirPending;
    logic     readEn;
    logic     inFlight;
    fetched_t fetched;

    logic     issue;
    logic     accepted;
    logic     redirNow;
    pc_t      redirTarget;

    // A read that met the wait request stays on the bus until accepted
    assign issue       = readEn && (inFlight || !i_Stall || !fetched.valid);
    assign accepted    = issue && !i_IBusWaitReq;
    assign redirNow    = i_Redirect || redirPending;
    assign redirTarget = i_Redirect ? i_Target : redirPc;

    assign o_IBusReq.addr = pc[31 -: `BUS_ADDR_W];
    assign o_IBusReq.read = issue;
    assign o_Fetched      = fetched;

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            pc           <= `CPU_RESET_PC;
            readEn       <= 1'b0;
            inFlight     <= 1'b0;
            redirPending <= 1'b0;
        end else begin
            readEn   <= 1'b1;
            inFlight <= issue && i_IBusWaitReq;
            if (accepted || (redirNow && !issue)) begin
                pc           <= redirNow ? redirTarget : pc + 32'd4;
                redirPending <= 1'b0;
            end else if (i_Redirect) begin
                // Wrong-path read still waiting, finish it before jumping
                redirPending <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_Redirect) begin
            redirPc <= i_Target;
        end
    end

    // Redirect squashes, stall holds, a waiting fetch sends a bubble
    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            fetched.valid <= 1'b0;
        end else if (redirNow) begin
            fetched.valid <= 1'b0;
        end else if (accepted) begin
            fetched <= '{valid: 1'b1, pc: pc, inst: i_IBusRdata};
        end else if (!i_Stall) begin
            fetched.valid <= 1'b0;
        end
    end

endmodule

/* hdl/isa_pkg.sv */
package isa_pkg;

    typedef logic [4:0]  regAddr_t;
    typedef logic [31:0] instr_t;
    typedef logic [31:0] pc_t;
    typedef logic [2:0]  funct3_t;

    // Major opcodes, anything else decodes as a no-op
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } aluOp_e;

    typedef enum logic [1:0] {
        UP_NONE,
        UP_LUI,
        UP_AUIPC
    } upper_e;

    typedef struct packed {
        aluOp_e aluOp;
        logic   bSelImm;
        upper_e upper;
        logic   isBranch;
        logic   isJal;
        logic   isJalr;
        logic   memRead;
        logic   memWrite;
        logic   regWrite;
    } ctrl_t;

    // Fetch stage output register
    typedef struct packed {
        logic   valid;
        pc_t    pc;
        instr_t inst;
    } fetched_t;

endpackage

/* hdl/loadStoreUnit.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module loadStoreUnit import isa_pkg::*, bus_pkg::*; (
    input  logic     i_Clk,
    input  logic     i_rstN,
    input  memOp_t   i_MemOp,
    output logic     o_Busy,
    output logic     o_DBusReq,
    input  logic     i_DBusGnt,
    output dBusReq_t o_DBus,
    input  word_t    i_DBusRdata,
    input  logic     i_DBusWaitReq,
    output logic     o_WbEn,
    output regAddr_t o_WbReg,
    output word_t    o_WbData
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GNT,
        ACCESS
    } lsuState_e;

    lsuState_e  state;
    lsuState_e  nextState;
    logic       isMem;
    logic       done;
    logic [1:0] offset;
    byteEn_t    byteEn;
    word_t      laneData;
    word_t      loadData;

    assign isMem  = i_MemOp.valid && (i_MemOp.isLoad || i_MemOp.isStore);
    assign done   = (state == ACCESS) && !i_DBusWaitReq;
    assign offset = i_MemOp.addr[1:0];

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (isMem) begin
                    nextState = i_DBusGnt ? ACCESS : WAIT_GNT;
                end
            end
            WAIT_GNT: begin
                if (i_DBusGnt) begin
                    nextState = ACCESS;
                end
            end
            ACCESS: begin
                if (!i_DBusWaitReq) begin
                    nextState = IDLE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Lanes from size and low address bits
    always_comb begin
        case (i_MemOp.size[1:0])
            2'b00:   byteEn = 4'b0001 << offset;
            2'b01:   byteEn = offset[1] ? 4'b1100 : 4'b0011;
            default: byteEn = 4'b1111;
        endcase
    end

    assign o_DBusReq     = isMem && (state != ACCESS);
    assign o_DBus.addr   = i_MemOp.addr[31 -: `BUS_ADDR_W];
    assign o_DBus.byteEn = byteEn;
    assign o_DBus.read   = (state == ACCESS) && i_MemOp.isLoad;
    assign o_DBus.write  = (state == ACCESS) && i_MemOp.isStore;
    assign o_DBus.wdata  = i_MemOp.storeData << {offset, 3'b000};

    assign laneData = i_DBusRdata >> {offset, 3'b000};

    always_comb begin
        case (i_MemOp.size)
            3'b000:  loadData = {{24{laneData[7]}}, laneData[7:0]};
            3'b001:  loadData = {{16{laneData[15]}}, laneData[15:0]};
            3'b100:  loadData = {24'd0, laneData[7:0]};
            3'b101:  loadData = {16'd0, laneData[15:0]};
            default: loadData = laneData;
        endcase
    end

    // Loads write back only in the completing cycle
    assign o_Busy   = isMem && !done;
    assign o_WbEn   = i_MemOp.valid && i_MemOp.regWrite && (!i_MemOp.isLoad || done);
    assign o_WbReg  = i_MemOp.rd;
    assign o_WbData = i_MemOp.isLoad ? loadData : i_MemOp.result;

endmodule

/* verilog.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/bus_pkg.sv
hdl/fetchUnit.sv
hdl/executeUnit.sv
hdl/loadStoreUnit.sv
hdl/cpuCore.sv
bench/memModel.sv
bench/cpuCore_asserts.sv
bench/tb_cpuCore.sv
